// File: source/shadow_pkg.sv
package shadow_pkg;

  // number of shadowed buffers
  localparam int NUM_BUFS = 4;

  // words per buffer
  localparam int DEPTH = 16;

  localparam int ADDR_W = 4;
  localparam int DATA_W = 8;

  // tag width on the write streams
  localparam int BUF_ID_W = 2;

  // word address inside one buffer
  typedef logic [ADDR_W-1:0] addr_t;

  // one buffer word, same for every buffer
  typedef logic [DATA_W-1:0] data_t;

  // selects the target buffer
  typedef logic [BUF_ID_W-1:0] buf_id_t;

endpackage

// File: source/shadow_lane_if.sv
interface shadow_lane_if;
  import shadow_pkg::*;

  // implementation side write strobe
  logic  impl_wen;
  addr_t impl_addr;
  data_t impl_data;

  // golden side write strobe
  logic  gold_wen;
  addr_t gold_addr;
  data_t gold_data;

  modport router (
    output impl_wen, impl_addr, impl_data,
    output gold_wen, gold_addr, gold_data
  );

  modport pair (
    input impl_wen, impl_addr, impl_data,
    input gold_wen, gold_addr, gold_data
  );

endinterface

// File: source/lane_result_if.sv
interface lane_result_if;
  import shadow_pkg::*;

  // one-cycle scan request
  logic  compare;

  // sticky once the scan ends
  logic  done;
  logic  mismatch;
  addr_t mismatch_addr;

  modport collector (
    output compare,
    input  done, mismatch, mismatch_addr
  );

  modport pair (
    input  compare,
    output done, mismatch, mismatch_addr
  );

endinterface

// File: source/session_window.sv
module session_window (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic finish,
  output logic recording,
  output logic compare
);

  logic started;
  logic finished;
  logic closing;

  // finish only counts while the window is open
  assign closing = recording && finish;

  assign recording = started && !finished;

  // one-shot open, a start after finish stays ignored
  always_ff @(posedge clk) begin
    if (rst) begin
      started <= 1'b0;
    end else if (start) begin
      started <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      finished <= 1'b0;
    end else if (closing) begin
      finished <= 1'b1;
    end
  end

  // pulse lands in the first cycle with recording low
  always_ff @(posedge clk) begin
    if (rst) begin
      compare <= 1'b0;
    end else begin
      compare <= closing;
    end
  end

endmodule

// File: source/write_router.sv
module write_router (
  input  logic                recording,
  input  logic                impl_wen,
  input  shadow_pkg::buf_id_t impl_buf,
  input  shadow_pkg::addr_t   impl_addr,
  input  shadow_pkg::data_t   impl_data,
  input  logic                gold_wen,
  input  shadow_pkg::buf_id_t gold_buf,
  input  shadow_pkg::addr_t   gold_addr,
  input  shadow_pkg::data_t   gold_data,
  shadow_lane_if.router       lanes [shadow_pkg::NUM_BUFS]
);
  import shadow_pkg::*;

  logic impl_live;
  logic gold_live;

  // writes outside the window never reach a lane
  assign impl_live = recording && impl_wen;
  assign gold_live = recording && gold_wen;

  for (genvar g = 0; g < NUM_BUFS; g++) begin : g_lane
    // tag decode to one strobe per stream
    assign lanes[g].impl_wen = impl_live && (impl_buf == buf_id_t'(g));
    assign lanes[g].gold_wen = gold_live && (gold_buf == buf_id_t'(g));

    // address and data go to every lane
    assign lanes[g].impl_addr = impl_addr;
    assign lanes[g].impl_data = impl_data;
    assign lanes[g].gold_addr = gold_addr;
    assign lanes[g].gold_data = gold_data;
  end

endmodule

// File: source/buffer_pair.sv
module buffer_pair (
  input  logic        clk,
  input  logic        rst,
  shadow_lane_if.pair lane,
  lane_result_if.pair result
);
  import shadow_pkg::*;

  data_t impl_mem [DEPTH];
  data_t gold_mem [DEPTH];

  logic  busy;
  addr_t scan_addr;
  logic  scan_last;

  // read stage of the scan
  logic  chk_valid;
  logic  chk_last;
  addr_t chk_addr;
  data_t rd_impl;
  data_t rd_gold;

  assign scan_last = (scan_addr == addr_t'(DEPTH - 1));

  // both sides start from zero so unwritten words agree
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        impl_mem[i] <= '0;
        gold_mem[i] <= '0;
      end
    end else begin
      if (lane.impl_wen) begin
        impl_mem[lane.impl_addr] <= lane.impl_data;
      end
      if (lane.gold_wen) begin
        gold_mem[lane.gold_addr] <= lane.gold_data;
      end
    end
  end

  // address walk
  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      scan_addr <= '0;
      chk_valid <= 1'b0;
      chk_last  <= 1'b0;
    end else begin
      chk_valid <= busy;
      chk_last  <= busy && scan_last;
      if (result.compare && !busy) begin
        busy      <= 1'b1;
        scan_addr <= '0;
      end else if (busy) begin
        scan_addr <= scan_addr + 1'b1;
        if (scan_last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_impl  <= impl_mem[scan_addr];
    rd_gold  <= gold_mem[scan_addr];
    chk_addr <= scan_addr;
  end

  // ascending walk, so the first hit is the lowest address
  always_ff @(posedge clk) begin
    if (rst) begin
      result.done          <= 1'b0;
      result.mismatch      <= 1'b0;
      result.mismatch_addr <= '0;
    end else if (chk_valid) begin
      if (rd_impl != rd_gold && !result.mismatch) begin
        result.mismatch      <= 1'b1;
        result.mismatch_addr <= chk_addr;
      end
      if (chk_last) begin
        result.done <= 1'b1;
      end
    end
  end

endmodule

// File: source/mismatch_collector.sv
module mismatch_collector (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 compare,
  lane_result_if.collector     results [shadow_pkg::NUM_BUFS],
  output logic                 done,
  output logic                 mismatch,
  output shadow_pkg::buf_id_t  mismatch_buf,
  output shadow_pkg::addr_t    mismatch_addr
);
  import shadow_pkg::*;

  logic [NUM_BUFS-1:0] lane_done;
  logic [NUM_BUFS-1:0] lane_mis;
  addr_t               lane_addr [NUM_BUFS];

  logic    all_done;
  buf_id_t sel_buf;
  addr_t   sel_addr;

  for (genvar g = 0; g < NUM_BUFS; g++) begin : g_lane
    // every scan starts on the same pulse
    assign results[g].compare = compare;
    assign lane_done[g]       = results[g].done;
    assign lane_mis[g]        = results[g].mismatch;
    assign lane_addr[g]       = results[g].mismatch_addr;
  end

  assign all_done = &lane_done;

  // lowest-numbered failing lane wins
  always_comb begin
    sel_buf  = '0;
    sel_addr = '0;
    for (int i = NUM_BUFS - 1; i >= 0; i--) begin
      if (lane_mis[i]) begin
        sel_buf  = buf_id_t'(i);
        sel_addr = lane_addr[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done     <= 1'b0;
      mismatch <= 1'b0;
    end else if (all_done && !done) begin
      done     <= 1'b1;
      mismatch <= |lane_mis;
    end
  end

  // report fields, held once done is set
  always_ff @(posedge clk) begin
    if (all_done && !done) begin
      mismatch_buf  <= sel_buf;
      mismatch_addr <= sel_addr;
    end
  end

endmodule

// File: source/shadow_check_top.sv
module shadow_check_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                finish,
  input  logic                impl_wen,
  input  shadow_pkg::buf_id_t impl_buf,
  input  shadow_pkg::addr_t   impl_addr,
  input  shadow_pkg::data_t   impl_data,
  input  logic                gold_wen,
  input  shadow_pkg::buf_id_t gold_buf,
  input  shadow_pkg::addr_t   gold_addr,
  input  shadow_pkg::data_t   gold_data,
  output logic                recording,
  output logic                done,
  output logic                mismatch,
  output shadow_pkg::buf_id_t mismatch_buf,
  output shadow_pkg::addr_t   mismatch_addr
);
  import shadow_pkg::*;

  logic compare;

  shadow_lane_if lane_bus [NUM_BUFS] ();
  lane_result_if result_bus [NUM_BUFS] ();

  session_window u_window (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .finish    (finish),
    .recording (recording),
    .compare   (compare)
  );

  write_router u_router (
    .recording (recording),
    .impl_wen  (impl_wen),
    .impl_buf  (impl_buf),
    .impl_addr (impl_addr),
    .impl_data (impl_data),
    .gold_wen  (gold_wen),
    .gold_buf  (gold_buf),
    .gold_addr (gold_addr),
    .gold_data (gold_data),
    .lanes     (lane_bus)
  );

  // one implementation/golden pair per buffer
  for (genvar g = 0; g < NUM_BUFS; g++) begin : g_pair
    buffer_pair u_pair (
      .clk    (clk),
      .rst    (rst),
      .lane   (lane_bus[g]),
      .result (result_bus[g])
    );
  end

  mismatch_collector u_collector (
    .clk           (clk),
    .rst           (rst),
    .compare       (compare),
    .results       (result_bus),
    .done          (done),
    .mismatch      (mismatch),
    .mismatch_buf  (mismatch_buf),
    .mismatch_addr (mismatch_addr)
  );

endmodule

// File: test/tb_shadow_check.sv
module tb_shadow_check;
  import shadow_pkg::*;

  localparam int DONE_LIMIT = 100;
  localparam int CHECK_LIMIT = 200;
  localparam logic [31:0] SEED = 32'h61dd;

  logic    clk;
  logic    rst;
  logic    start;
  logic    finish;
  logic    impl_wen;
  logic    gold_wen;
  buf_id_t impl_buf;
  buf_id_t gold_buf;
  addr_t   impl_addr;
  addr_t   gold_addr;
  data_t   impl_data;
  data_t   gold_data;
  logic    recording;
  logic    done;
  logic    mismatch;
  buf_id_t mismatch_buf;
  addr_t   mismatch_addr;

  // model of both memories and of the run window
  data_t       impl_ref [NUM_BUFS][DEPTH];
  data_t       gold_ref [NUM_BUFS][DEPTH];
  logic        win_open;
  logic        win_closed;
  logic [31:0] lfsr;
  string       test_name;
  int          checks_req;
  int          checks_done;
  event        result_due;

  shadow_check_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("FAIL %s %s: expected %0h, actual %0h",
                         test_name, what, expected, actual));
    end
  endtask

  // galois lfsr, one step per bit
  function automatic logic [31:0] take_bits(int n);
    logic [31:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) begin
        lfsr = lfsr ^ 32'h80200003;
      end
      v = {v[30:0], lsb};
    end
    return v;
  endfunction

  // lowest buffer first, then lowest address
  function automatic void expected_result(output logic mis, output buf_id_t b,
                                          output addr_t a);
    mis = 1'b0;
    b   = '0;
    a   = '0;
    for (int i = 0; i < NUM_BUFS; i++) begin
      for (int j = 0; j < DEPTH; j++) begin
        if (!mis && impl_ref[i][j] != gold_ref[i][j]) begin
          mis = 1'b1;
          b   = buf_id_t'(i);
          a   = addr_t'(j);
        end
      end
    end
  endfunction

  task automatic reset_dut();
    rst      = 1'b1;
    start    = 1'b0;
    finish   = 1'b0;
    impl_wen = 1'b0;
    gold_wen = 1'b0;
    for (int i = 0; i < NUM_BUFS; i++) begin
      for (int j = 0; j < DEPTH; j++) begin
        impl_ref[i][j] = '0;
        gold_ref[i][j] = '0;
      end
    end
    win_open   = 1'b0;
    win_closed = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  task automatic do_start();
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    if (!win_closed) begin
      win_open = 1'b1;
    end
  endtask

  task automatic do_finish();
    finish = 1'b1;
    @(posedge clk);
    #1;
    finish = 1'b0;
    if (win_open) begin
      win_open   = 1'b0;
      win_closed = 1'b1;
    end
  endtask

  task automatic write_word(logic to_impl, logic to_gold, buf_id_t b, addr_t a,
                            data_t di, data_t dg);
    impl_wen  = to_impl;
    impl_buf  = b;
    impl_addr = a;
    impl_data = di;
    gold_wen  = to_gold;
    gold_buf  = b;
    gold_addr = a;
    gold_data = dg;
    // only writes inside the window land, last one wins
    if (win_open && to_impl) begin
      impl_ref[b][a] = di;
    end
    if (win_open && to_gold) begin
      gold_ref[b][a] = dg;
    end
    @(posedge clk);
    #1;
    impl_wen = 1'b0;
    gold_wen = 1'b0;
  endtask

  task automatic random_writes(int count);
    buf_id_t b;
    addr_t   a;
    data_t   d;
    for (int i = 0; i < count; i++) begin
      b = buf_id_t'(take_bits(BUF_ID_W));
      a = addr_t'(take_bits(ADDR_W));
      d = data_t'(take_bits(DATA_W));
      write_word(1'b1, 1'b1, b, a, d, d);
    end
  endtask

  task automatic check_recording(logic expected);
    @(negedge clk);
    check_value("recording", 32'(expected), 32'(recording));
    @(posedge clk);
    #1;
  endtask

  task automatic finish_and_request();
    do_finish();
    checks_req++;
    -> result_due;
  endtask

  task automatic await_check();
    int n;
    n = 0;
    while (checks_done < checks_req && n < CHECK_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (checks_done < checks_req) begin
      fail_run("the result check did not complete in time");
    end
  endtask

  // result checker, cycles counted from the edge that samples finish
  initial begin : result_check
    logic    exp_mis;
    buf_id_t exp_buf;
    addr_t   exp_addr;
    int      cycles;
    forever begin
      @(result_due);
      @(negedge clk);
      cycles = 0;
      while (!done && cycles < DONE_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (!done) begin
        fail_run($sformatf("done never rose after finish in test %s", test_name));
      end else begin
        expected_result(exp_mis, exp_buf, exp_addr);
        check_value("latency", DEPTH + 3, cycles);
        check_value("mismatch", 32'(exp_mis), 32'(mismatch));
        if (exp_mis) begin
          check_value("mismatch_buf", 32'(exp_buf), 32'(mismatch_buf));
          check_value("mismatch_addr", 32'(exp_addr), 32'(mismatch_addr));
        end
        checks_done++;
      end
    end
  end

  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    finish      = 1'b0;
    impl_wen    = 1'b0;
    impl_buf    = '0;
    impl_addr   = '0;
    impl_data   = '0;
    gold_wen    = 1'b0;
    gold_buf    = '0;
    gold_addr   = '0;
    gold_data   = '0;
    lfsr        = SEED;
    checks_req  = 0;
    checks_done = 0;

    test_name = "identical";
    reset_dut();
    do_start();
    random_writes(48);
    finish_and_request();
    await_check();

    test_name = "single_diff";
    reset_dut();
    do_start();
    random_writes(24);
    write_word(1'b1, 1'b1, 2'd2, 4'd9, 8'h3c, 8'h66);
    finish_and_request();
    await_check();

    test_name = "multi_diff";
    reset_dut();
    do_start();
    random_writes(24);
    write_word(1'b1, 1'b1, 2'd3, 4'd1, 8'h10, 8'hef);
    write_word(1'b1, 1'b1, 2'd1, 4'd12, 8'h21, 8'hde);
    write_word(1'b1, 1'b1, 2'd1, 4'd5, 8'h42, 8'hbd);
    write_word(1'b1, 1'b1, 2'd2, 4'd0, 8'h84, 8'h7b);
    finish_and_request();
    await_check();

    // writes outside the window must not count
    test_name = "window";
    reset_dut();
    write_word(1'b1, 1'b0, 2'd0, 4'd3, 8'ha5, 8'h00);
    check_recording(1'b0);
    do_start();
    check_recording(1'b1);
    finish_and_request();
    check_recording(1'b0);
    write_word(1'b1, 1'b0, 2'd1, 4'd7, 8'h5a, 8'h00);
    do_start();
    check_recording(1'b0);
    await_check();

    test_name = "last_write";
    reset_dut();
    do_start();
    write_word(1'b1, 1'b0, 2'd2, 4'd4, 8'h3c, 8'h00);
    write_word(1'b1, 1'b1, 2'd0, 4'd8, 8'h11, 8'h22);
    write_word(1'b0, 1'b1, 2'd0, 4'd8, 8'h00, 8'h11);
    finish_and_request();
    await_check();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: filelist.f
source/shadow_pkg.sv
source/shadow_lane_if.sv
source/lane_result_if.sv
source/session_window.sv
source/write_router.sv
source/buffer_pair.sv
source/mismatch_collector.sv
source/shadow_check_top.sv
test/tb_shadow_check.sv

// File: Makefile
TOP = tb_shadow_check

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module shadow_check_top
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
